//--- hdl/tsp_pkg.sv
`default_nettype none

package tsp_pkg;

    localparam int city_num = 16;
    localparam int city_log = 4;
    localparam int dist_w   = 8;
    localparam int total_w  = 12;  // Holds 16 edges of the largest distance.
    localparam int delta_w  = 10;

    typedef logic [city_log-1:0] city_t;  // Serves as city index and as tour position.

    typedef logic [dist_w-1:0] dist_t;

    typedef logic [total_w-1:0] total_t;

    typedef logic signed [delta_w-1:0] delta_t;

endpackage

`default_nettype wire

//--- hdl/move_gen.sv
`timescale 1ns/1ps
`default_nettype none

module move_gen (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           seed_load,
    input  logic [63:0]    seed,
    input  logic           move_take,
    output tsp_pkg::city_t pos_k,
    output tsp_pkg::city_t pos_l,
    output logic [7:0]     r_metro
);

    import tsp_pkg::*;

    logic [63:0]       state;
    logic [63:0]       x1;
    logic [63:0]       x2;
    logic [63:0]       next_state;
    city_t             a_pick;
    city_t             b_pick;
    city_t             lo;
    city_t             hi;
    logic [city_log:0] span;

    always_comb begin
        x1         = state ^ (state << 13);
        x2         = x1 ^ (x1 >> 7);
        next_state = x2 ^ (x2 << 17);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= 64'd1;
        end else if (seed_load) begin
            state <= (seed == 64'd0) ? 64'd1 : seed;  // Xorshift locks up on an all-zero state.
        end else if (move_take) begin
            state <= next_state;
        end
    end

    assign a_pick  = state[city_log-1:0];
    assign b_pick  = state[city_log+7:8];
    assign lo      = (a_pick < b_pick) ? a_pick : b_pick;
    assign hi      = (a_pick < b_pick) ? b_pick : a_pick;
    assign span    = {1'b0, hi} - {1'b0, lo};
    assign r_metro = state[63:56];

    // Pairs that are too close or that wrap onto each other fall back to a short move.
    always_comb begin
        if (span >= 2 && !(lo == '0 && hi == city_t'(city_num - 1))) begin
            pos_k = lo;
            pos_l = hi;
        end else begin
            pos_k = {1'b0, lo[city_log-2:0]};
            pos_l = {1'b0, lo[city_log-2:0]} + city_t'(2);
        end
    end

    a_legal_pair: assert property (@(posedge clk) disable iff (!arst_n)
        ({1'b0, pos_l} >= {1'b0, pos_k} + 2'd2) &&
        !(pos_k == '0 && pos_l == city_t'(city_num - 1)));

endmodule

`default_nettype wire

//--- hdl/distance_table.sv
`timescale 1ns/1ps
`default_nettype none

module distance_table (
    input  logic           clk,
    input  logic           dist_write,
    input  logic [7:0]     dist_addr,
    input  tsp_pkg::dist_t dist_data,
    input  logic [7:0]     rd_a_addr,
    input  logic [7:0]     rd_b_addr,
    output tsp_pkg::dist_t rd_a_data,
    output tsp_pkg::dist_t rd_b_data
);

    import tsp_pkg::*;

    dist_t mem [city_num*city_num];  // Row city in the upper nibble of the address.

    always_ff @(posedge clk) begin
        if (dist_write) begin
            mem[dist_addr] <= dist_data;
        end
    end

    assign rd_a_data = mem[rd_a_addr];
    assign rd_b_data = mem[rd_b_addr];

endmodule

`default_nettype wire

//--- hdl/tour_ram.sv
`timescale 1ns/1ps
`default_nettype none

module tour_ram (
    input  logic           clk,
    input  logic           arst_n,
    input  tsp_pkg::city_t rd_pos [4],
    input  logic           commit,
    input  tsp_pkg::city_t pos_k,
    input  tsp_pkg::city_t pos_l,
    input  tsp_pkg::city_t tour_rd_addr,
    output tsp_pkg::city_t rd_city [4],
    output tsp_pkg::city_t tour_rd_data,
    output logic           rev_busy
);

    import tsp_pkg::*;

    city_t tour [city_num];
    city_t lo;
    city_t hi;
    logic  active;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < city_num; i++) begin
                tour[i] <= city_t'(i);  // Identity tour.
            end
            lo     <= '0;
            hi     <= '0;
            active <= 1'b0;
        end else if (active) begin
            tour[lo] <= tour[hi];
            tour[hi] <= tour[lo];
            lo       <= lo + 1'b1;
            hi       <= hi - 1'b1;
            if (hi - lo <= city_t'(2)) begin
                active <= 1'b0;  // Ends meet after this swap.
            end
        end else if (commit) begin
            lo     <= pos_k + 1'b1;
            hi     <= pos_l;
            active <= 1'b1;
        end
    end

    always_comb begin
        for (int j = 0; j < 4; j++) begin
            rd_city[j] = tour[rd_pos[j]];
        end
    end

    assign tour_rd_data = tour[tour_rd_addr];
    assign rev_busy     = active;

    a_commit_idle: assert property (@(posedge clk) disable iff (!arst_n)
        commit |-> !rev_busy);

endmodule

`default_nettype wire

//--- hdl/delta_calc.sv
`timescale 1ns/1ps
`default_nettype none

module delta_calc (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            run,
    input  logic            init,
    input  logic            rev_busy,
    input  tsp_pkg::city_t  pos_k,
    input  tsp_pkg::city_t  pos_l,
    input  tsp_pkg::city_t  rd_city [4],
    input  tsp_pkg::dist_t  rd_a_data,
    input  tsp_pkg::dist_t  rd_b_data,
    output logic            move_take,
    output tsp_pkg::city_t  rd_pos [4],
    output logic [7:0]      rd_a_addr,
    output logic [7:0]      rd_b_addr,
    output logic            delta_valid,
    output tsp_pkg::delta_t delta,
    output tsp_pkg::total_t init_total,
    output logic            total_valid,
    output logic            busy
);

    import tsp_pkg::*;

    typedef enum logic [3:0] {
        S_IDLE,
        S_FETCH,
        S_DIST1,
        S_DIST2,
        S_DELTA,
        S_HOLD,
        S_WAIT,
        S_SUM,
        S_TOTAL
    } state_t;

    state_t          state;
    city_t           cnt;
    city_t           city_a;
    city_t           city_b;
    city_t           city_c;
    city_t           city_d;
    logic [dist_w:0] sum_new;
    logic [dist_w:0] sum_cross;
    total_t          acc;

    assign sum_new = rd_a_data + rd_b_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    cnt <= '0;
                    if (init) begin
                        state <= S_SUM;
                    end else if (run) begin
                        state <= S_FETCH;
                    end
                end
                S_FETCH: state <= S_DIST1;
                S_DIST1: state <= S_DIST2;
                S_DIST2: state <= S_DELTA;
                S_DELTA: state <= S_HOLD;
                S_HOLD:  state <= S_WAIT;  // Gives the decision time to start a reversal.
                S_WAIT: begin
                    if (!rev_busy) begin
                        state <= S_IDLE;
                    end
                end
                S_SUM: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == city_t'(city_num - 1)) begin
                        state <= S_TOTAL;
                    end
                end
                S_TOTAL: state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            S_IDLE:  acc <= '0;
            S_SUM:   acc <= acc + total_t'(rd_a_data);
            S_FETCH: begin
                city_a <= rd_city[0];
                city_b <= rd_city[1];
                city_c <= rd_city[2];
                city_d <= rd_city[3];
            end
            S_DIST1: sum_cross <= sum_new;  // New edges d(a,c) + d(b,d).
            S_DIST2: delta <= delta_t'(sum_cross) - delta_t'(sum_new);
            default: ;
        endcase
    end

    always_comb begin
        rd_pos[0] = pos_k;
        rd_pos[1] = pos_k + 1'b1;
        rd_pos[2] = pos_l;
        rd_pos[3] = pos_l + 1'b1;  // Wraps to position 0 after the last city.
        rd_a_addr = {city_a, city_c};
        rd_b_addr = {city_b, city_d};
        if (state == S_SUM) begin
            rd_pos[0] = cnt;
            rd_pos[1] = cnt + 1'b1;
            rd_a_addr = {rd_city[0], rd_city[1]};
        end else if (state == S_DIST2) begin
            rd_a_addr = {city_a, city_b};
            rd_b_addr = {city_c, city_d};
        end
    end

    assign move_take   = (state == S_IDLE) && run && !init;
    assign delta_valid = (state == S_DELTA);
    assign total_valid = (state == S_TOTAL);
    assign init_total  = acc;
    assign busy        = (state != S_IDLE);

endmodule

`default_nettype wire

//--- hdl/metropolis.sv
`timescale 1ns/1ps
`default_nettype none

module metropolis (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            delta_valid,
    input  tsp_pkg::delta_t delta,
    input  logic [7:0]      r_metro,
    input  logic [7:0]      temperature,
    input  tsp_pkg::city_t  pos_k,
    input  tsp_pkg::city_t  pos_l,
    input  logic            total_valid,
    input  tsp_pkg::total_t init_total,
    input  logic            rev_busy,
    output logic            commit,
    output tsp_pkg::total_t total_distance,
    output logic            iter_done,
    output logic            accepted
);

    import tsp_pkg::*;

    logic [7:0]                threshold;
    logic                      take;
    logic                      pending;
    logic signed [total_w+1:0] new_total;

    assign threshold = r_metro & temperature;  // Hot runs allow larger uphill moves.
    assign take      = (delta <= 0) || (delta < delta_t'(threshold));
    assign new_total = $signed({2'b00, total_distance}) + delta;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            commit         <= 1'b0;
            pending        <= 1'b0;
            iter_done      <= 1'b0;
            accepted       <= 1'b0;
            total_distance <= '0;
        end else begin
            commit    <= 1'b0;
            iter_done <= 1'b0;
            accepted  <= 1'b0;
            if (total_valid) begin
                total_distance <= init_total;
            end
            if (delta_valid) begin
                if (take) begin
                    total_distance <= new_total[total_w-1:0];
                    commit         <= 1'b1;
                    pending        <= 1'b1;
                end else begin
                    iter_done <= 1'b1;
                end
            end else if (pending && !commit && !rev_busy) begin
                pending   <= 1'b0;  // Reversal has finished.
                iter_done <= 1'b1;
                accepted  <= 1'b1;
            end
        end
    end

    a_total_no_wrap: assert property (@(posedge clk) disable iff (!arst_n)
        (delta_valid && take) |-> (new_total >= 0 && new_total < (1 << total_w)));

    a_move_held: assert property (@(posedge clk) disable iff (!arst_n)
        delta_valid |=> ($stable(pos_k) && $stable(pos_l)));

endmodule

`default_nettype wire

//--- hdl/anneal_replica.sv
`timescale 1ns/1ps
`default_nettype none

module anneal_replica (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            dist_write,
    input  logic [7:0]      dist_addr,
    input  tsp_pkg::dist_t  dist_data,
    input  logic            init,
    input  logic            seed_load,
    input  logic [63:0]     seed,
    input  logic            run,
    input  logic [7:0]      temperature,
    input  tsp_pkg::city_t  tour_rd_addr,
    output tsp_pkg::city_t  tour_rd_data,
    output tsp_pkg::total_t total_distance,
    output logic            iter_done,
    output logic            accepted,
    output logic            busy
);

    import tsp_pkg::*;

    city_t      pos_k;
    city_t      pos_l;
    logic [7:0] r_metro;
    logic       move_take;
    city_t      rd_pos [4];
    city_t      rd_city [4];
    logic [7:0] rd_a_addr;
    logic [7:0] rd_b_addr;
    dist_t      rd_a_data;
    dist_t      rd_b_data;
    logic       delta_valid;
    delta_t     delta;
    total_t     init_total;
    logic       total_valid;
    logic       commit;
    logic       rev_busy;

    move_gen move_gen_inst (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .seed_load ( seed_load ),
        .seed      ( seed      ),
        .move_take ( move_take ),
        .pos_k     ( pos_k     ),
        .pos_l     ( pos_l     ),
        .r_metro   ( r_metro   )
    );

    distance_table distance_table_inst (
        .clk        ( clk        ),
        .dist_write ( dist_write ),
        .dist_addr  ( dist_addr  ),
        .dist_data  ( dist_data  ),
        .rd_a_addr  ( rd_a_addr  ),
        .rd_b_addr  ( rd_b_addr  ),
        .rd_a_data  ( rd_a_data  ),
        .rd_b_data  ( rd_b_data  )
    );

    tour_ram tour_ram_inst (
        .clk          ( clk          ),
        .arst_n       ( arst_n       ),
        .rd_pos       ( rd_pos       ),
        .commit       ( commit       ),
        .pos_k        ( pos_k        ),
        .pos_l        ( pos_l        ),
        .tour_rd_addr ( tour_rd_addr ),
        .rd_city      ( rd_city      ),
        .tour_rd_data ( tour_rd_data ),
        .rev_busy     ( rev_busy     )
    );

    delta_calc delta_calc_inst (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .run         ( run         ),
        .init        ( init        ),
        .rev_busy    ( rev_busy    ),
        .pos_k       ( pos_k       ),
        .pos_l       ( pos_l       ),
        .rd_city     ( rd_city     ),
        .rd_a_data   ( rd_a_data   ),
        .rd_b_data   ( rd_b_data   ),
        .move_take   ( move_take   ),
        .rd_pos      ( rd_pos      ),
        .rd_a_addr   ( rd_a_addr   ),
        .rd_b_addr   ( rd_b_addr   ),
        .delta_valid ( delta_valid ),
        .delta       ( delta       ),
        .init_total  ( init_total  ),
        .total_valid ( total_valid ),
        .busy        ( busy        )
    );

    metropolis metropolis_inst (
        .clk            ( clk            ),
        .arst_n         ( arst_n         ),
        .delta_valid    ( delta_valid    ),
        .delta          ( delta          ),
        .r_metro        ( r_metro        ),
        .temperature    ( temperature    ),
        .pos_k          ( pos_k          ),
        .pos_l          ( pos_l          ),
        .total_valid    ( total_valid    ),
        .init_total     ( init_total     ),
        .rev_busy       ( rev_busy       ),
        .commit         ( commit         ),
        .total_distance ( total_distance ),
        .iter_done      ( iter_done      ),
        .accepted       ( accepted       )
    );

endmodule

`default_nettype wire

//--- tb/tb_anneal_replica.sv
`timescale 1ns/1ps
`default_nettype none

module tb_anneal_replica;

    import tsp_pkg::*;

    // About 600 iterations of at most 20 cycles plus table loading, with a wide margin.
    localparam int max_cycles = 200000;
    localparam int init_cycles = city_num + 1;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        dist_write;
    logic [7:0]  dist_addr;
    dist_t       dist_data;
    logic        init;
    logic        seed_load;
    logic [63:0] seed;
    logic        run;
    logic [7:0]  temperature;
    city_t       tour_rd_addr;
    city_t       tour_rd_data;
    total_t      total_distance;
    logic        iter_done;
    logic        accepted;
    logic        busy;

    int          ref_dist [city_num][city_num];  // Copy of every distance written to the DUT.
    int          tour_cities [city_num];
    logic [31:0] rng_state = 32'd74;
    int          cycle_count = 0;
    int          errors = 0;

    anneal_replica anneal_replica_inst (
        .clk            ( clk            ),
        .arst_n         ( arst_n         ),
        .dist_write     ( dist_write     ),
        .dist_addr      ( dist_addr      ),
        .dist_data      ( dist_data      ),
        .init           ( init           ),
        .seed_load      ( seed_load      ),
        .seed           ( seed           ),
        .run            ( run            ),
        .temperature    ( temperature    ),
        .tour_rd_addr   ( tour_rd_addr   ),
        .tour_rd_data   ( tour_rd_data   ),
        .total_distance ( total_distance ),
        .iter_done      ( iter_done      ),
        .accepted       ( accepted       ),
        .busy           ( busy           )
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("Timeout: the DUT did not finish its work within %0d cycles.", max_cycles);
            $display("Finished with errors");
            $fatal(1, "Run stopped by the cycle limit.");
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
            $display("Finished with errors");
            $fatal(1, "Stopped at the first mismatch.");
        end
    endtask

    task automatic fail_now(input string what);
        errors++;
        $display("Error at %0t ns: %s", $time, what);
        $display("Finished with errors");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic write_distance(input int row, input int col, input int value);
        dist_addr  = 8'(row * city_num + col);
        dist_data  = dist_t'(value);
        dist_write = 1'b1;
        @(negedge clk);
        dist_write = 1'b0;
    endtask

    task automatic load_distances();
        int d;
        for (int r = 0; r < city_num; r++) begin
            ref_dist[r][r] = 0;
            write_distance(r, r, 0);
            for (int c = r + 1; c < city_num; c++) begin
                rng_state = xorshift32(rng_state);
                d = 1 + int'(rng_state % 32'd63);
                ref_dist[r][c] = d;
                ref_dist[c][r] = d;
                write_distance(r, c, d);
                write_distance(c, r, d);
            end
        end
    endtask

    task automatic load_seed();
        rng_state = xorshift32(rng_state);
        seed[63:32] = rng_state;
        rng_state = xorshift32(rng_state);
        seed[31:0] = rng_state;
        seed_load  = 1'b1;
        @(negedge clk);
        seed_load = 1'b0;
    endtask

    // The sum lands in total_distance in the cycle in which busy falls.
    task automatic pulse_init();
        int cycles;
        cycles = 0;
        init = 1'b1;
        @(negedge clk);
        init = 1'b0;
        while (busy) begin
            cycles++;
            @(negedge clk);
        end
        check_value("busy cycles after init", cycles, init_cycles);
    endtask

    task automatic read_tour();
        tour_rd_addr = '0;
        for (int i = 0; i < city_num; i++) begin
            @(negedge clk);
            tour_cities[i] = int'(tour_rd_data);
            if (i < city_num - 1) begin
                tour_rd_addr = city_t'(i + 1);
            end
        end
    endtask

    function automatic int tour_length();
        int sum;
        sum = 0;
        for (int i = 0; i < city_num; i++) begin
            sum += ref_dist[tour_cities[i]][tour_cities[(i + 1) % city_num]];
        end
        return sum;
    endfunction

    task automatic verify_tour();
        int seen [city_num];
        read_tour();
        for (int c = 0; c < city_num; c++) begin
            seen[c] = 0;
        end
        for (int i = 0; i < city_num; i++) begin
            seen[tour_cities[i]]++;
        end
        for (int c = 0; c < city_num; c++) begin
            check_value($sformatf("count of city %0d in tour", c), seen[c], 1);
        end
        check_value("total_distance", total_distance, tour_length());
    endtask

    task automatic run_iterations(input int count, input bit cold);
        int done;
        int accepts;
        int prev_total;
        bit draining;
        done       = 0;
        accepts    = 0;
        prev_total = int'(total_distance);
        draining   = 1'b0;
        run        = 1'b1;
        while (!(draining && !busy && !iter_done)) begin
            @(negedge clk);
            if (iter_done) begin
                done++;
                if (accepted) begin
                    accepts++;
                end
                if (cold && total_distance > prev_total) begin
                    fail_now($sformatf("total_distance rose from %0d to %0d at temperature 0",
                                       prev_total, total_distance));
                end
                if (total_distance < prev_total) begin
                    check_value("accepted", accepted, 1'b1);
                end
                if (!accepted) begin
                    check_value("total_distance", total_distance, prev_total);
                end
                prev_total = int'(total_distance);
                if (done == count) begin
                    run      = 1'b0;  // The iteration in flight is allowed to finish.
                    draining = 1'b1;
                end
            end
        end
        if (accepts == 0) begin
            fail_now($sformatf("no move was accepted in %0d iterations", count));
        end
    endtask

    task automatic check_after_reset();
        check_value("busy", busy, 1'b0);
        check_value("iter_done", iter_done, 1'b0);
        check_value("accepted", accepted, 1'b0);
        check_value("total_distance", total_distance, 0);
        read_tour();
        for (int i = 0; i < city_num; i++) begin
            check_value($sformatf("tour_rd_data at position %0d", i), tour_cities[i], i);
        end
    endtask

    task automatic check_initial_length();
        load_distances();
        pulse_init();
        for (int i = 0; i < city_num; i++) begin
            tour_cities[i] = i;  // Identity tour.
        end
        check_value("total_distance", total_distance, tour_length());
    endtask

    task automatic idle_hold();
        int pulses;
        int saved;
        pulses = 0;
        repeat (100) begin
            @(negedge clk);
            if (iter_done) begin
                pulses++;
            end
        end
        check_value("iter_done pulses with run low", pulses, 0);
        saved = int'(total_distance);
        pulse_init();
        check_value("total_distance", total_distance, saved);
    endtask

    initial begin
        arst_n       = 1'b0;
        dist_write   = 1'b0;
        dist_addr    = '0;
        dist_data    = '0;
        init         = 1'b0;
        seed_load    = 1'b0;
        seed         = '0;
        run          = 1'b0;
        temperature  = '0;
        tour_rd_addr = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        check_after_reset();
        check_initial_length();

        load_seed();
        temperature = 8'h00;
        run_iterations(300, 1'b1);
        verify_tour();

        temperature = 8'hFF;  // Uphill moves become possible.
        run_iterations(300, 1'b0);
        verify_tour();

        idle_hold();

        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
hdl/tsp_pkg.sv
hdl/move_gen.sv
hdl/distance_table.sv
hdl/tour_ram.sv
hdl/delta_calc.sv
hdl/metropolis.sv
hdl/anneal_replica.sv
tb/tb_anneal_replica.sv

//--- Bender.yml
package:
  name: anneal_replica

sources:
  - hdl/tsp_pkg.sv
  - hdl/move_gen.sv
  - hdl/distance_table.sv
  - hdl/tour_ram.sv
  - hdl/delta_calc.sv
  - hdl/metropolis.sv
  - hdl/anneal_replica.sv
  - target: test
    files:
      - tb/tb_anneal_replica.sv
